// ==== design/clock_pkg.sv ====
// Digital clock shared types
package clock_pkg;

	// ------------------------------------------------------------------------
	// Controller state
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_t;

	// ------------------------------------------------------------------------
	// Data widths and limits
	// ------------------------------------------------------------------------
	typedef logic [5:0] field_t;	// 0..59 fits in six bits
	typedef logic [3:0] bcd_t;
	typedef logic [6:0] seg_t;	// a..g, a in the MSB
	typedef logic [5:0] digit_en_t;	// Active low

	localparam int NUM_DIGITS = 6;
	localparam int SEC_MAX    = 59;	// Minutes share it
	localparam int HOUR_MAX   = 23;

	// Next value of a field that rolls over after its limit
	function automatic field_t wrap_inc(input field_t value, input field_t limit);
		return (value == limit) ? '0 : value + 1'b1;
	endfunction

endpackage

// ==== design/tick_gen.sv ====
// Strobe divider
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_strobe
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (o_strobe) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign o_strobe = (cnt == CW'(DIV - 1));	// Last count of the period

	// The divider needs at least two counts per period
	a_div_min: assert property (@(posedge clk) disable iff (!rst_n) DIV >= 2);

endmodule

// ==== design/button_sync.sv ====
// Push button synchronizer
`timescale 1ns/1ps

module button_sync (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [3:0] i_btn_n,	// 0 mode, 1 position, 2 set, 3 alarm
	output logic [3:0] o_press
);

	logic [3:0] sync_meta;
	logic [3:0] sync_btn;
	logic [3:0] btn_prev;

	// ------------------------------------------------------------------------
	// Two flops into the clk domain, then edge detect
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_meta <= '1;	// Released
			sync_btn  <= '1;
			btn_prev  <= '1;
		end else begin
			sync_meta <= i_btn_n;
			sync_btn  <= sync_meta;
			btn_prev  <= sync_btn;
		end
	end

	// High to low on a synchronized button is a press
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_press <= '0;
		end else begin
			o_press <= btn_prev & ~sync_btn;
		end
	end

endmodule

// ==== design/clock_ctrl.sv ====
// Clock mode controller
`timescale 1ns/1ps

module clock_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [3:0]        i_press,
	input  logic              i_sec_strobe,
	output clock_pkg::mode_t  o_mode,
	output clock_pkg::pos_t   o_position,
	output logic              o_alarm_en,
	output logic              o_time_tick,
	output logic [2:0]        o_inc_time,	// Indexed by pos_t
	output logic [2:0]        o_inc_alarm
);

	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_SET   = 2;
	localparam int BTN_ALARM = 3;

	logic [2:0] pos_sel;

	// ------------------------------------------------------------------------
	// Registered state
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= clock_pkg::MODE_CLOCK;
			o_position <= clock_pkg::POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_press[BTN_MODE]) begin
				case (o_mode)
					clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: o_mode <= clock_pkg::MODE_ALARM;
					default:               o_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (i_press[BTN_POS]) begin
				case (o_position)
					clock_pkg::POS_SEC: o_position <= clock_pkg::POS_MIN;
					clock_pkg::POS_MIN: o_position <= clock_pkg::POS_HOUR;
					default:            o_position <= clock_pkg::POS_SEC;
				endcase
			end
			if (i_press[BTN_ALARM])
				o_alarm_en <= ~o_alarm_en;
		end
	end

	// ------------------------------------------------------------------------
	// Tick and set routing
	// ------------------------------------------------------------------------
	always_comb begin
		pos_sel     = 3'b001 << o_position;
		o_time_tick = i_sec_strobe && (o_mode != clock_pkg::MODE_SETUP);	// Frozen in setup
		o_inc_time  = '0;
		o_inc_alarm = '0;
		if (i_press[BTN_SET]) begin
			case (o_mode)
				clock_pkg::MODE_SETUP: o_inc_time  = pos_sel;
				clock_pkg::MODE_ALARM: o_inc_alarm = pos_sel;
				default: ;	// Set does nothing while the clock runs
			endcase
		end
	end

	// Only one field in one of the two counters moves per set press
	a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
		(i_press[BTN_SET] && o_mode != clock_pkg::MODE_CLOCK) |->
		$onehot({o_inc_time, o_inc_alarm}));

endmodule

// ==== design/time_counter.sv ====
// Time of day counter
`timescale 1ns/1ps

module time_counter (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_tick,
	input  logic [2:0]        i_inc,
	output clock_pkg::field_t o_sec,
	output clock_pkg::field_t o_min,
	output clock_pkg::field_t o_hour
);

	localparam clock_pkg::field_t SEC_LIM  = clock_pkg::field_t'(clock_pkg::SEC_MAX);
	localparam clock_pkg::field_t HOUR_LIM = clock_pkg::field_t'(clock_pkg::HOUR_MAX);

	// ------------------------------------------------------------------------
	// Running time with carries, setting without
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec  <= '0;
			o_min  <= '0;
			o_hour <= '0;
		end else if (i_tick) begin
			o_sec <= clock_pkg::wrap_inc(o_sec, SEC_LIM);
			if (o_sec == SEC_LIM) begin	// Carry into minutes
				o_min <= clock_pkg::wrap_inc(o_min, SEC_LIM);
				if (o_min == SEC_LIM)
					o_hour <= clock_pkg::wrap_inc(o_hour, HOUR_LIM);
			end
		end else begin
			// Ticks are held off in setup, so these never meet a tick
			if (i_inc[clock_pkg::POS_SEC])
				o_sec <= clock_pkg::wrap_inc(o_sec, SEC_LIM);
			if (i_inc[clock_pkg::POS_MIN])
				o_min <= clock_pkg::wrap_inc(o_min, SEC_LIM);
			if (i_inc[clock_pkg::POS_HOUR])
				o_hour <= clock_pkg::wrap_inc(o_hour, HOUR_LIM);
		end
	end

	a_sec_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_sec <= SEC_LIM);

	a_min_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_min <= SEC_LIM);

	a_hour_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_hour <= HOUR_LIM);

endmodule

// ==== design/alarm_unit.sv ====
// Alarm time and match
`timescale 1ns/1ps

module alarm_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [2:0]        i_inc,
	input  logic              i_alarm_en,
	input  clock_pkg::field_t i_sec,
	input  clock_pkg::field_t i_min,
	input  clock_pkg::field_t i_hour,
	output clock_pkg::field_t o_alarm_sec,
	output clock_pkg::field_t o_alarm_min,
	output clock_pkg::field_t o_alarm_hour,
	output logic              o_alarm
);

	localparam clock_pkg::field_t SEC_LIM  = clock_pkg::field_t'(clock_pkg::SEC_MAX);
	localparam clock_pkg::field_t HOUR_LIM = clock_pkg::field_t'(clock_pkg::HOUR_MAX);

	logic match;

	// Alarm time registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_sec  <= '0;
			o_alarm_min  <= '0;
			o_alarm_hour <= '0;
		end else begin
			if (i_inc[clock_pkg::POS_SEC])
				o_alarm_sec <= clock_pkg::wrap_inc(o_alarm_sec, SEC_LIM);
			if (i_inc[clock_pkg::POS_MIN])
				o_alarm_min <= clock_pkg::wrap_inc(o_alarm_min, SEC_LIM);
			if (i_inc[clock_pkg::POS_HOUR])
				o_alarm_hour <= clock_pkg::wrap_inc(o_alarm_hour, HOUR_LIM);
		end
	end

	// ------------------------------------------------------------------------
	// Match latch
	// ------------------------------------------------------------------------
	assign match = (i_sec == o_alarm_sec) && (i_min == o_alarm_min) &&
		(i_hour == o_alarm_hour);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (o_alarm | match);	// Held until disabled
		end
	end

	a_alarm_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		o_alarm |-> $past(i_alarm_en));

endmodule

// ==== design/display_scan.sv ====
// Seven segment display scanner
`timescale 1ns/1ps

module display_scan (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_scan_strobe,
	input  clock_pkg::mode_t     i_mode,
	input  clock_pkg::field_t    i_sec,
	input  clock_pkg::field_t    i_min,
	input  clock_pkg::field_t    i_hour,
	input  clock_pkg::field_t    i_alarm_sec,
	input  clock_pkg::field_t    i_alarm_min,
	input  clock_pkg::field_t    i_alarm_hour,
	output clock_pkg::seg_t      o_seg,
	output logic                 o_seg_dp,
	output clock_pkg::digit_en_t o_seg_enb
);

	localparam int IDX_W = $clog2(clock_pkg::NUM_DIGITS);

	logic [IDX_W-1:0]  scan_idx;
	clock_pkg::field_t show_sec;
	clock_pkg::field_t show_min;
	clock_pkg::field_t show_hour;
	clock_pkg::bcd_t   digit [clock_pkg::NUM_DIGITS];

	function automatic clock_pkg::seg_t seg_decode(input clock_pkg::bcd_t value);
		clock_pkg::seg_t pattern;
		case (value)
			4'd0:    pattern = 7'b111_1110;
			4'd1:    pattern = 7'b011_0000;
			4'd2:    pattern = 7'b110_1101;
			4'd3:    pattern = 7'b111_1001;
			4'd4:    pattern = 7'b011_0011;
			4'd5:    pattern = 7'b101_1011;
			4'd6:    pattern = 7'b101_1111;
			4'd7:    pattern = 7'b111_0000;
			4'd8:    pattern = 7'b111_1111;
			4'd9:    pattern = 7'b111_0011;
			default: pattern = 7'b000_0000;	// Blank
		endcase
		return pattern;
	endfunction

	// ------------------------------------------------------------------------
	// Field select and digit split
	// ------------------------------------------------------------------------
	always_comb begin
		if (i_mode == clock_pkg::MODE_ALARM) begin
			show_sec  = i_alarm_sec;
			show_min  = i_alarm_min;
			show_hour = i_alarm_hour;
		end else begin
			show_sec  = i_sec;
			show_min  = i_min;
			show_hour = i_hour;
		end
		digit[0] = clock_pkg::bcd_t'(show_sec / 6'd10);
		digit[1] = clock_pkg::bcd_t'(show_sec % 6'd10);
		digit[2] = clock_pkg::bcd_t'(show_min / 6'd10);
		digit[3] = clock_pkg::bcd_t'(show_min % 6'd10);
		digit[4] = clock_pkg::bcd_t'(show_hour / 6'd10);
		digit[5] = clock_pkg::bcd_t'(show_hour % 6'd10);
	end

	// ------------------------------------------------------------------------
	// Scan index and output registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (i_scan_strobe) begin
			if (scan_idx == IDX_W'(clock_pkg::NUM_DIGITS - 1))
				scan_idx <= '0;
			else
				scan_idx <= scan_idx + 1'b1;
		end
	end

	// Pattern and enable change on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= 7'b111_1110;	// Digit 0 of an all-zero time
			o_seg_enb <= 6'b111110;
		end else begin
			o_seg     <= seg_decode(digit[scan_idx]);
			o_seg_enb <= ~(clock_pkg::digit_en_t'(1) << scan_idx);
		end
	end

	assign o_seg_dp = 1'b0;

	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~o_seg_enb) == 1);

endmodule

// ==== design/digital_clock_top.sv ====
// Digital clock top level
`timescale 1ns/1ps

module digital_clock_top #(
	parameter int SEC_DIV  = 50_000_000,	// Clocks per second
	parameter int SCAN_DIV = 50_000	// Clocks per digit
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [3:0]           i_btn_n,
	output clock_pkg::seg_t      o_seg,
	output logic                 o_seg_dp,
	output clock_pkg::digit_en_t o_seg_enb,
	output logic                 o_alarm
);

	logic              sec_strobe;
	logic              scan_strobe;
	logic [3:0]        press;
	clock_pkg::mode_t  mode;
	logic              alarm_en;
	logic              time_tick;
	logic [2:0]        inc_time;
	logic [2:0]        inc_alarm;
	clock_pkg::field_t sec;
	clock_pkg::field_t min;
	clock_pkg::field_t hour;
	clock_pkg::field_t alarm_sec;
	clock_pkg::field_t alarm_min;
	clock_pkg::field_t alarm_hour;

	tick_gen #(.DIV(SEC_DIV)) u_sec_tick (
		.clk(clk), .rst_n(rst_n), .o_strobe(sec_strobe));

	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (
		.clk(clk), .rst_n(rst_n), .o_strobe(scan_strobe));

	button_sync u_button_sync (
		.clk(clk), .rst_n(rst_n), .i_btn_n(i_btn_n), .o_press(press));

	clock_ctrl u_clock_ctrl (
		.clk(clk), .rst_n(rst_n), .i_press(press), .i_sec_strobe(sec_strobe),
		.o_mode(mode), .o_position(), .o_alarm_en(alarm_en),	// Cursor stays internal
		.o_time_tick(time_tick), .o_inc_time(inc_time), .o_inc_alarm(inc_alarm));

	time_counter u_time_counter (
		.clk(clk), .rst_n(rst_n), .i_tick(time_tick), .i_inc(inc_time),
		.o_sec(sec), .o_min(min), .o_hour(hour));

	alarm_unit u_alarm_unit (
		.clk(clk), .rst_n(rst_n), .i_inc(inc_alarm), .i_alarm_en(alarm_en),
		.i_sec(sec), .i_min(min), .i_hour(hour),
		.o_alarm_sec(alarm_sec), .o_alarm_min(alarm_min), .o_alarm_hour(alarm_hour),
		.o_alarm(o_alarm));

	display_scan u_display_scan (
		.clk(clk), .rst_n(rst_n), .i_scan_strobe(scan_strobe), .i_mode(mode),
		.i_sec(sec), .i_min(min), .i_hour(hour),
		.i_alarm_sec(alarm_sec), .i_alarm_min(alarm_min), .i_alarm_hour(alarm_hour),
		.o_seg(o_seg), .o_seg_dp(o_seg_dp), .o_seg_enb(o_seg_enb));

endmodule

// ==== testbench/tb_digital_clock.sv ====
// Digital clock testbench
`timescale 1ns/1ps

module tb_digital_clock;

	localparam int SEC_DIV      = 200;
	localparam int SCAN_DIV     = 2;
	localparam int READ_TIMEOUT = 100;	// One full scan with margin

	localparam int BTN_MODE  = 0;	// i_btn_n bit order
	localparam int BTN_POS   = 1;
	localparam int BTN_SET   = 2;
	localparam int BTN_ALARM = 3;

	localparam int F_SEC  = 0;
	localparam int F_MIN  = 1;
	localparam int F_HOUR = 2;

	localparam int M_CLOCK = 0;
	localparam int M_SETUP = 1;
	localparam int M_ALARM = 2;

	localparam int OP_PRESS      = 0;	// arg button, val count, -1 random
	localparam int OP_SETFIELD   = 1;	// arg field, val target
	localparam int OP_WAIT       = 2;	// arg seconds
	localparam int OP_READ       = 3;	// val hhmmss or -1 for model plus arg seconds
	localparam int OP_ALARM_WAIT = 4;	// arg timeout in seconds
	localparam int OP_ALARM_HOLD = 5;	// val level, arg seconds

	logic       clk;
	logic       rst_n;
	logic [3:0] i_btn_n;
	logic [6:0] o_seg;
	logic       o_seg_dp;
	logic [5:0] o_seg_enb;
	logic       o_alarm;

	string t_name[$];
	int    t_op[$];
	int    t_arg[$];
	int    t_val[$];
	int    t_slack[$];

	// Reference model of the controller and counters
	int m_mode;
	int m_pos;
	int m_time[3];
	int m_alarm[3];

	int errors;
	int checks;
	int seed;

	digital_clock_top #(.SEC_DIV(SEC_DIV), .SCAN_DIV(SCAN_DIV)) digital_clock_top_i (
		.clk(clk), .rst_n(rst_n), .i_btn_n(i_btn_n), .o_seg(o_seg),
		.o_seg_dp(o_seg_dp), .o_seg_enb(o_seg_enb), .o_alarm(o_alarm));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	function automatic int field_limit(input int f);
		return (f == F_HOUR) ? 24 : 60;
	endfunction

	function automatic int shown_value();
		if (m_mode == M_ALARM)
			return m_alarm[F_HOUR] * 10000 + m_alarm[F_MIN] * 100 + m_alarm[F_SEC];
		return m_time[F_HOUR] * 10000 + m_time[F_MIN] * 100 + m_time[F_SEC];
	endfunction

	function automatic int hms_to_sec(input int v);
		return (v / 10000) * 3600 + ((v / 100) % 100) * 60 + v % 100;
	endfunction

	function automatic int sec_to_hms(input int s);
		int t;
		t = s % 86400;
		return (t / 3600) * 10000 + ((t / 60) % 60) * 100 + t % 60;
	endfunction

	// Segments a..g back to a digit, -1 if no digit
	function automatic int seg_to_digit(input logic [6:0] p);
		int d;
		case (p)
			7'b1111110: d = 0;
			7'b0110000: d = 1;
			7'b1101101: d = 2;
			7'b1111001: d = 3;
			7'b0110011: d = 4;
			7'b1011011: d = 5;
			7'b1011111: d = 6;
			7'b1110000: d = 7;
			7'b1111111: d = 8;
			7'b1110011: d = 9;
			default:    d = -1;
		endcase
		return d;
	endfunction

	function automatic int low_digit(input logic [5:0] enb);
		int idx;
		int zeros;
		idx   = -1;
		zeros = 0;
		for (int i = 0; i < 6; i++) begin
			if (!enb[i]) begin
				zeros++;
				idx = i;
			end
		end
		return (zeros == 1) ? idx : -1;
	endfunction

	task automatic add_row(input string name, input int op, input int arg, input int val,
		input int slack);
		t_name.push_back(name);
		t_op.push_back(op);
		t_arg.push_back(arg);
		t_val.push_back(val);
		t_slack.push_back(slack);
	endtask

	task automatic model_press(input int b);
		if (b == BTN_MODE) begin
			m_mode = (m_mode + 1) % 3;
		end else if (b == BTN_POS) begin
			m_pos = (m_pos + 1) % 3;
		end else if (b == BTN_SET) begin
			if (m_mode == M_SETUP)
				m_time[m_pos] = (m_time[m_pos] + 1) % field_limit(m_pos);
			else if (m_mode == M_ALARM)
				m_alarm[m_pos] = (m_alarm[m_pos] + 1) % field_limit(m_pos);
		end
	endtask

	// Six cycles low, six high, per press
	task automatic press(input int b, input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			i_btn_n[b] <= 1'b0;
			repeat (6) @(posedge clk);
			i_btn_n[b] <= 1'b1;
			repeat (5) @(posedge clk);
			model_press(b);
		end
	endtask

	task automatic set_field(input int f, input int target);
		int cur;
		for (int k = 0; k < 3 && m_pos != f; k++)
			press(BTN_POS, 1);
		cur = (m_mode == M_ALARM) ? m_alarm[f] : m_time[f];
		press(BTN_SET, (target - cur + field_limit(f)) % field_limit(f));
	endtask

	task automatic read_display(input string name, output int value);
		int digits[6];
		int seen;
		int cycles;
		int k;
		int d;
		seen   = 0;
		cycles = 0;
		value  = -1;
		while (seen != 'h3F && cycles < READ_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			k = low_digit(o_seg_enb);
			d = seg_to_digit(o_seg);
			if (k >= 0 && d >= 0) begin
				digits[k] = d;
				seen |= 1 << k;
			end
		end
		if (seen != 'h3F) begin
			errors++;
			$display("%s: display did not show all six digits within %0d cycles",
				name, READ_TIMEOUT);
		end else begin
			value = (digits[4] * 10 + digits[5]) * 10000 + (digits[2] * 10 + digits[3]) * 100 +
				digits[0] * 10 + digits[1];
		end
	endtask

	task automatic check_read(input string name, input int offset, input int val,
		input int slack);
		int got;
		int exp;
		int diff;
		read_display(name, got);
		exp = (val >= 0) ? val : sec_to_hms(hms_to_sec(shown_value()) + offset);
		checks++;
		if (got >= 0) begin
			diff = hms_to_sec(got) - hms_to_sec(exp);
			if (diff > 43200)
				diff -= 86400;
			if (diff < -43200)
				diff += 86400;
			assert (diff <= slack && diff >= -slack) else begin
				errors++;
				$display("CHECK FAILED %s: expected %06d (+/- %0d s), actual %06d",
					name, exp, slack, got);
			end
			if (m_mode != M_ALARM) begin	// Frozen time read back into the model
				m_time[F_HOUR] = got / 10000;
				m_time[F_MIN]  = (got / 100) % 100;
				m_time[F_SEC]  = got % 100;
			end
		end
	endtask

	task automatic alarm_wait(input string name, input int secs);
		int n;
		n = 0;
		while (o_alarm !== 1'b1 && n < secs * SEC_DIV) begin
			@(negedge clk);
			n++;
		end
		checks++;
		assert (o_alarm === 1'b1) else begin
			errors++;
			$display("%s: o_alarm did not rise within %0d s", name, secs);
		end
	endtask

	task automatic alarm_hold(input string name, input logic level, input int secs);
		int   limit;
		int   n;
		logic bad;
		logic got;
		limit = (secs > 0) ? secs * SEC_DIV : 1;
		n     = 0;
		bad   = 1'b0;
		got   = level;
		while (n < limit && !bad) begin
			@(negedge clk);
			n++;
			if (o_alarm !== level) begin
				bad = 1'b1;
				got = o_alarm;
			end
		end
		checks++;
		assert (!bad) else begin
			errors++;
			$display("CHECK FAILED %s: expected o_alarm %0b, actual %0b", name, level, got);
		end
		checks++;
		assert (o_seg_dp === 1'b0 && low_digit(o_seg_enb) >= 0) else begin
			errors++;
			$display("CHECK FAILED %s: expected dp 0 and one enable low, actual dp %0b enb %b",
				name, o_seg_dp, o_seg_enb);
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus table
	// ------------------------------------------------------------------------
	task automatic build_table();
		add_row("reset_outputs",     OP_ALARM_HOLD, 0,         0,      0);
		add_row("enter_setup",       OP_PRESS,      BTN_MODE,  1,      0);
		add_row("reset_time",        OP_READ,       0,         0,      0);
		add_row("sec_random",        OP_PRESS,      BTN_SET,   -1,     0);
		add_row("to_minutes",        OP_PRESS,      BTN_POS,   1,      0);
		add_row("min_random",        OP_PRESS,      BTN_SET,   -1,     0);
		add_row("to_hours",          OP_PRESS,      BTN_POS,   1,      0);
		add_row("hour_random",       OP_PRESS,      BTN_SET,   -1,     0);
		add_row("setup_fields",      OP_READ,       0,         -1,     0);
		add_row("preset_hour",       OP_SETFIELD,   F_HOUR,    23,     0);
		add_row("preset_min",        OP_SETFIELD,   F_MIN,     59,     0);
		add_row("preset_sec",        OP_SETFIELD,   F_SEC,     57,     0);
		add_row("preset_read",       OP_READ,       0,         235957, 0);
		add_row("leave_setup",       OP_PRESS,      BTN_MODE,  2,      0);
		add_row("run_5s",            OP_WAIT,       5,         0,      0);
		add_row("freeze",            OP_PRESS,      BTN_MODE,  1,      0);
		add_row("midnight_rollover", OP_READ,       0,         2,      1);
		add_row("to_alarm",          OP_PRESS,      BTN_MODE,  1,      0);
		add_row("alarm_initial",     OP_READ,       0,         0,      0);
		add_row("alarm_min",         OP_SETFIELD,   F_MIN,     7,      0);
		add_row("alarm_hour",        OP_SETFIELD,   F_HOUR,    5,      0);
		add_row("alarm_read",        OP_READ,       0,         050700, 0);
		add_row("alarm_run",         OP_WAIT,       2,         0,      0);
		add_row("alarm_to_setup",    OP_PRESS,      BTN_MODE,  2,      0);
		add_row("time_kept_running", OP_READ,       3,         -1,     1);
		add_row("match_hour",        OP_SETFIELD,   F_HOUR,    5,      0);
		add_row("match_min",         OP_SETFIELD,   F_MIN,     6,      0);
		add_row("match_sec",         OP_SETFIELD,   F_SEC,     57,     0);
		add_row("match_read",        OP_READ,       0,         050657, 0);
		add_row("alarm_enable",      OP_PRESS,      BTN_ALARM, 1,      0);
		add_row("alarm_idle",        OP_ALARM_HOLD, 0,         0,      0);
		add_row("run_to_match",      OP_PRESS,      BTN_MODE,  2,      0);
		add_row("alarm_rises",       OP_ALARM_WAIT, 6,         0,      0);
		add_row("alarm_latched",     OP_ALARM_HOLD, 2,         1,      0);
		add_row("alarm_disable",     OP_PRESS,      BTN_ALARM, 1,      0);
		add_row("alarm_cleared",     OP_ALARM_HOLD, 1,         0,      0);
		add_row("refreeze",          OP_PRESS,      BTN_MODE,  1,      0);
		add_row("time_after_alarm",  OP_READ,       6,         -1,     1);
		add_row("again_min",         OP_SETFIELD,   F_MIN,     6,      0);
		add_row("again_sec",         OP_SETFIELD,   F_SEC,     57,     0);
		add_row("again_read",        OP_READ,       0,         050657, 0);
		add_row("run_disabled",      OP_PRESS,      BTN_MODE,  2,      0);
		add_row("disabled_match",    OP_ALARM_HOLD, 6,         0,      0);
	endtask

	initial begin
		int count;
		errors  = 0;
		checks  = 0;
		seed    = 29;
		m_mode  = M_CLOCK;
		m_pos   = F_SEC;
		m_time  = '{0, 0, 0};
		m_alarm = '{0, 0, 0};
		rst_n   = 1'b0;
		i_btn_n = 4'hF;	// All released
		build_table();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		for (int i = 0; i < t_op.size(); i++) begin
			case (t_op[i])
				OP_PRESS: begin
					count = (t_val[i] < 0) ? {$random(seed)} % 100 : t_val[i];
					press(t_arg[i], count);
				end
				OP_SETFIELD:   set_field(t_arg[i], t_val[i]);
				OP_WAIT:       repeat (t_arg[i] * SEC_DIV) @(posedge clk);
				OP_READ:       check_read(t_name[i], t_arg[i], t_val[i], t_slack[i]);
				OP_ALARM_WAIT: alarm_wait(t_name[i], t_arg[i]);
				default:       alarm_hold(t_name[i], t_val[i] != 0, t_arg[i]);
			endcase
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== build.f ====
design/clock_pkg.sv
design/tick_gen.sv
design/button_sync.sv
design/clock_ctrl.sv
design/time_counter.sv
design/alarm_unit.sv
design/display_scan.sv
design/digital_clock_top.sv
testbench/tb_digital_clock.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the digital clock testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_digital_clock \
	-f build.f -o tb_digital_clock
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_digital_clock)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1
